//--- hdl/ch3_pkg.sv
package ch3_pkg;

	// one wishbone classic request, held by the master until ack
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [4:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// channel setup as written through NR30..NR34
	typedef struct packed {
		logic        dac_en;   // NR30 bit 7
		logic [7:0]  len_load; // NR31
		logic [1:0]  vol;      // NR32 bits 6:5
		logic [10:0] freq;     // NR34[2:0] and NR33
		logic        len_en;   // NR34 bit 6
	} ch3_cfg_t;

	localparam logic [4:0] ADR_NR30      = 5'h00;
	localparam logic [4:0] ADR_NR31      = 5'h01;
	localparam logic [4:0] ADR_NR32      = 5'h02;
	localparam logic [4:0] ADR_NR33      = 5'h03;
	localparam logic [4:0] ADR_NR34      = 5'h04;
	localparam logic [4:0] ADR_WAVE_BASE = 5'h10;

	// output level codes of NR32
	localparam logic [1:0] VOL_MUTE    = 2'd0;
	localparam logic [1:0] VOL_FULL    = 2'd1;
	localparam logic [1:0] VOL_HALF    = 2'd2;
	localparam logic [1:0] VOL_QUARTER = 2'd3;

endpackage

//--- hdl/ch3_regs.sv
`timescale 1ns/10ps

module ch3_regs import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	input  logic [7:0] ram_rdat,
	output wb_rsp_t    wb_rsp,
	output ch3_cfg_t   cfg,
	output logic       trigger,
	output logic       len_write,
	output logic       ram_we,
	output logic [3:0] ram_adr,
	output logic [7:0] ram_wdat
);

	logic       ack;
	logic       req_go;
	logic       wr_go;
	logic       wave_sel;
	logic [7:0] rd_dat;

	assign req_go   = wb_req.cyc && wb_req.stb && !ack; // first sampled cycle only
	assign wr_go    = req_go && wb_req.we;
	assign wave_sel = (wb_req.adr >= ADR_WAVE_BASE);

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req_go; // one cycle, then low again
		end
	end

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			cfg       <= '0;
			trigger   <= 1'b0;
			len_write <= 1'b0;
		end else begin
			trigger   <= 1'b0;
			len_write <= 1'b0;
			if (wr_go) begin
				case (wb_req.adr)
					ADR_NR30: cfg.dac_en <= wb_req.dat[7];
					ADR_NR31: begin
						cfg.len_load <= wb_req.dat;
						len_write    <= 1'b1; // counter loads in the ack cycle
					end
					ADR_NR32: cfg.vol <= wb_req.dat[6:5];
					ADR_NR33: cfg.freq[7:0] <= wb_req.dat;
					ADR_NR34: begin
						cfg.freq[10:8] <= wb_req.dat[2:0];
						cfg.len_en     <= wb_req.dat[6];
						trigger        <= wb_req.dat[7];
					end
					default: ; // unused offsets and wave RAM
				endcase
			end
		end
	end

	// wave RAM writes land on the ack edge
	assign ram_we   = wr_go && wave_sel;
	assign ram_adr  = wb_req.adr[3:0];
	assign ram_wdat = wb_req.dat;

	always_comb begin
		case (wb_req.adr)
			ADR_NR30: rd_dat = {cfg.dac_en, 7'h7f};
			ADR_NR31: rd_dat = 8'hff; // write only
			ADR_NR32: rd_dat = {1'b1, cfg.vol, 5'h1f};
			ADR_NR33: rd_dat = 8'hff;
			ADR_NR34: rd_dat = {1'b1, cfg.len_en, 6'h3f};
			default:  rd_dat = wave_sel ? ram_rdat : 8'hff;
		endcase
	end

	assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

//--- hdl/ch3_wave_ram.sv
`timescale 1ns/10ps

module ch3_wave_ram (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  logic       ram_we,
	input  logic [3:0] ram_adr,
	input  logic [7:0] ram_wdat,
	input  logic [4:0] pos,
	output logic [7:0] ram_rdat,
	output logic [3:0] nibble
);

	logic [7:0] mem [16]; // 32 four-bit samples
	logic [7:0] play_byte;

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				mem[i] <= 8'h00;
			end
		end else if (ram_we) begin
			mem[ram_adr] <= ram_wdat;
		end
	end

	assign ram_rdat  = mem[ram_adr];
	assign play_byte = mem[pos[4:1]];

	// high nibble plays first
	assign nibble = pos[0] ? play_byte[3:0] : play_byte[7:4];

endmodule

//--- hdl/ch3_freq_timer.sv
`timescale 1ns/10ps

module ch3_freq_timer import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  ch3_cfg_t   cfg,
	input  logic       trigger,
	input  logic       ch_on,
	output logic [4:0] pos,
	output logic       step
);

	logic [10:0] cnt;
	logic        wrap;

	assign wrap = (cnt == 11'h7ff);

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= 11'd0;
			pos  <= 5'd0;
			step <= 1'b0;
		end else begin
			step <= 1'b0;
			if (trigger && cfg.dac_en) begin
				cnt <= cfg.freq; // restart from sample 0
				pos <= 5'd0;
			end else if (ch_on) begin
				if (wrap) begin
					cnt  <= cfg.freq; // period is 2048 - freq cycles
					pos  <= pos + 5'd1; // wraps at 32
					step <= 1'b1;
				end else begin
					cnt <= cnt + 11'd1;
				end
			end
		end
	end

endmodule

//--- hdl/ch3_length_ctr.sv
`timescale 1ns/10ps

module ch3_length_ctr import ch3_pkg::*; #(
	parameter int LEN_TICK_DIV = 8192
) (
	input  logic     cery_2mhz,
	input  logic     rst_n,
	input  ch3_cfg_t cfg,
	input  logic     trigger,
	input  logic     len_write,
	output logic     ch_on
);

	localparam int DIV_W = $clog2(LEN_TICK_DIV);

	logic [DIV_W-1:0] div;
	logic             tick;
	logic [8:0]       len;  // 256 means expired
	logic             len_step;
	logic             trig_go;

	assign tick     = (div == DIV_W'(LEN_TICK_DIV - 1));
	assign trig_go  = trigger && cfg.dac_en;
	assign len_step = tick && cfg.len_en && ch_on;

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			div <= '0;
		end else begin
			div <= tick ? '0 : div + 1'b1; // stands in for the frame sequencer
		end
	end

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			len <= 9'd0;
		end else if (len_write) begin
			len <= {1'b0, cfg.len_load};
		end else if (trig_go) begin
			if (len[8])
				len <= {1'b0, cfg.len_load}; // reload only once expired
		end else if (len_step) begin
			len <= len + 9'd1;
		end
	end

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			ch_on <= 1'b0;
		end else if (!cfg.dac_en) begin
			ch_on <= 1'b0; // DAC off kills the channel
		end else if (trigger) begin
			ch_on <= 1'b1;
		end else if (len_step && len == 9'd255) begin
			ch_on <= 1'b0; // length expired
		end
	end

endmodule

//--- hdl/ch3_level_out.sv
`timescale 1ns/10ps

module ch3_level_out import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  ch3_cfg_t   cfg,
	input  logic       ch_on,
	input  logic [3:0] nibble,
	output logic [3:0] sample_out
);

	logic [3:0] level;

	always_comb begin
		case (cfg.vol)
			VOL_FULL:    level = nibble;
			VOL_HALF:    level = nibble >> 1;
			VOL_QUARTER: level = nibble >> 2;
			default:     level = 4'd0; // mute
		endcase
	end

	always_ff @(posedge cery_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			sample_out <= 4'd0;
		end else begin
			sample_out <= ch_on ? level : 4'd0; // silent when channel is off
		end
	end

endmodule

//--- hdl/ch3_top.sv
`timescale 1ns/10ps

module ch3_top import ch3_pkg::*; #(
	parameter int LEN_TICK_DIV = 8192
) (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	output logic       ch_on,
	output logic [3:0] sample_out
);

	ch3_cfg_t   cfg;
	logic       trigger;
	logic       len_write;
	logic       ram_we;
	logic [3:0] ram_adr;
	logic [7:0] ram_wdat;
	logic [7:0] ram_rdat;
	logic [4:0] pos;
	logic       step; // one pulse per sample advance
	logic [3:0] nibble;

	ch3_regs i_regs (
		.cery_2mhz, .rst_n, .wb_req, .ram_rdat,
		.wb_rsp, .cfg, .trigger, .len_write,
		.ram_we, .ram_adr, .ram_wdat
	);

	ch3_wave_ram i_wave_ram (
		.cery_2mhz, .rst_n, .ram_we, .ram_adr, .ram_wdat,
		.pos, .ram_rdat, .nibble
	);

	ch3_freq_timer i_freq_timer (
		.cery_2mhz, .rst_n, .cfg, .trigger, .ch_on,
		.pos, .step
	);

	ch3_length_ctr #(
		.LEN_TICK_DIV(LEN_TICK_DIV)
	) i_length_ctr (
		.cery_2mhz, .rst_n, .cfg, .trigger, .len_write,
		.ch_on
	);

	ch3_level_out i_level_out (
		.cery_2mhz, .rst_n, .cfg, .ch_on, .nibble,
		.sample_out
	);

endmodule

//--- verif/ch3_tb_assert.sv
`timescale 1ns/10ps

module ch3_tb_assert import ch3_pkg::*; (
	input logic       cery_2mhz,
	input logic       rst_n,
	input wb_req_t    wb_req,
	input wb_rsp_t    wb_rsp,
	input ch3_cfg_t   cfg,
	input logic       ch_on,
	input logic [3:0] sample_out
);

	int n_ack = 0;
	int n_req = 0;
	int n_out = 0;
	int n_dac = 0;
	int fails; // assertion failures so far

	assign fails = n_ack + n_req + n_out + n_dac;

	ack_single: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		n_ack++;
		$error("ack stayed high for more than one cycle");
	end

	// ack only ever answers a sampled request
	ack_after_req: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
	else begin
		n_req++;
		$error("ack raised without a request");
	end

	out_silent: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		!ch_on |=> (sample_out == 4'd0))
	else begin
		n_out++;
		$error("sample_out not zero one cycle after ch_on was low");
	end

	dac_gates_on: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		!cfg.dac_en |=> !ch_on) // clear lands one edge later
	else begin
		n_dac++;
		$error("ch_on high while the DAC is disabled");
	end

endmodule

bind ch3_top ch3_tb_assert i_assert (
	.cery_2mhz(cery_2mhz), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
	.cfg(cfg), .ch_on(ch_on), .sample_out(sample_out)
);

//--- verif/ch3_tb.sv
`timescale 1ns/10ps

module ch3_tb import ch3_pkg::*; ();

	logic        cery_2mhz;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        ch_on;
	logic [3:0]  sample_out;
	logic [31:0] lfsr;
	logic [7:0]  wave [16]; // copy of the wave RAM contents
	int          err_cnt = 0;
	int          err_mark = 0;
	int          test_num = 0;
	int          test_fails = 0;

	ch3_top #(.LEN_TICK_DIV(4)) i_dut (.*);

	initial begin
		cery_2mhz = 1'b0;
		forever #20 cery_2mhz = ~cery_2mhz;
	end

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // one step per bit
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// readback value of an offset after writing d to it
	function automatic logic [7:0] reg_mask(input logic [4:0] adr, input logic [7:0] d);
		case (adr)
			ADR_NR30: return (d & 8'h80) | 8'h7f;
			ADR_NR32: return (d & 8'h60) | 8'h9f;
			ADR_NR34: return (d & 8'h40) | 8'hbf;
			default:  return 8'hff;
		endcase
	endfunction

	// codes 1 to 3 shift right by 0 to 2, code 0 mutes
	function automatic logic [3:0] scaled(input logic [1:0] vol, input logic [3:0] n);
		if (vol == VOL_MUTE)
			return 4'd0;
		return n >> (vol - 2'd1);
	endfunction

	function automatic int total_errors();
		return err_cnt + i_dut.i_assert.fails;
	endfunction

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (total_errors() == err_mark) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			test_fails++;
			$display("test %0d %s: failed with %0d errors", test_num, name,
				total_errors() - err_mark);
		end
		err_mark = total_errors();
	endtask

	// called on a falling edge, returns on the falling edge after the ack cycle
	task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
			output logic [7:0] rdat);
		int n;
		n = 0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge cery_2mhz);
			n++;
		end while (!wb_rsp.ack && n < 16);
		rdat = wb_rsp.dat;
		if (!wb_rsp.ack) begin
			err_cnt++;
			$display("no ack for offset %h within %0d cycles", adr, n);
		end
		wb_req = '0;
		@(negedge cery_2mhz); // stb low in the cycle after ack
	endtask

	task automatic wb_write(input logic [4:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [4:0] adr, output logic [7:0] dat);
		bus_cycle(1'b0, adr, 8'h00, dat);
	endtask

	task automatic wait_step();
		int n;
		n = 0;
		do begin
			@(negedge cery_2mhz);
			n++;
		end while (!i_dut.step && n < 16);
		if (!i_dut.step) begin
			err_cnt++;
			$display("no sample step within %0d cycles", n);
		end
		@(negedge cery_2mhz); // output follows pos one cycle later
	endtask

	initial begin
		logic [7:0] rd;
		logic [7:0] wr [16];
		logic [3:0] nib;
		int         n;
		lfsr = 32'hfb9fa61d;
		rst_n = 1'b0;
		wb_req = '0;
		repeat (4) @(negedge cery_2mhz);
		rst_n = 1'b1;
		@(negedge cery_2mhz);

		check("wb_rsp.ack", {7'd0, wb_rsp.ack}, 8'd0);
		check("ch_on", {7'd0, ch_on}, 8'd0);
		check("sample_out", {4'd0, sample_out}, 8'd0);
		for (int a = 0; a < 5; a++) begin
			wb_read(5'(a), rd);
			check($sformatf("wb_rsp.dat @%02h", a), rd, reg_mask(5'(a), 8'h00));
		end
		end_test("reset state");

		for (int a = 0; a < 16; a++) begin
			wr[4'(a)] = rand_byte();
			wb_write(5'(a), wr[4'(a)]);
		end
		for (int a = 0; a < 16; a++) begin
			wb_read(5'(a), rd);
			check($sformatf("wb_rsp.dat @%02h", a), rd, reg_mask(5'(a), wr[4'(a)]));
		end
		wb_write(ADR_NR30, 8'h00);
		end_test("register readback");

		for (int a = 0; a < 16; a++) begin
			wave[4'(a)] = rand_byte();
			wb_write(ADR_WAVE_BASE | 5'(a), wave[4'(a)]);
		end
		for (int a = 0; a < 16; a++) begin
			wb_read(ADR_WAVE_BASE | 5'(a), rd);
			check($sformatf("wb_rsp.dat @%02h", a + 16), rd, wave[4'(a)]);
		end
		end_test("wave RAM");

		wb_write(ADR_NR30, 8'h80);
		wb_write(ADR_NR33, 8'hf8); // freq 2040, eight cycles per step
		for (int v = 0; v < 4; v++) begin
			wb_write(ADR_NR32, {1'b0, 2'(v), 5'd0});
			wb_write(ADR_NR34, 8'h87);
			repeat (2) @(negedge cery_2mhz);
			for (int k = 0; k < 32; k++) begin
				if (k > 0)
					wait_step();
				nib = k[0] ? wave[4'(k / 2)][3:0] : wave[4'(k / 2)][7:4];
				check($sformatf("sample_out vol %0d pos %0d", v, k), {4'd0, sample_out},
					{4'd0, scaled(2'(v), nib)});
			end
		end
		end_test("playback");

		wb_write(ADR_NR31, 8'd250);
		wb_write(ADR_NR34, 8'hc7); // length on, trigger
		n = 0;
		while (ch_on && n < 32) begin // six ticks of four cycles plus margin
			@(negedge cery_2mhz);
			n++;
		end
		if (ch_on) begin
			err_cnt++;
			$display("ch_on still high %0d cycles after trigger with length 250", n);
		end
		wb_write(ADR_NR31, 8'd250);
		wb_write(ADR_NR34, 8'h87);
		@(negedge cery_2mhz);
		n = 0;
		while (ch_on && n < 32) begin
			@(negedge cery_2mhz);
			n++;
		end
		if (!ch_on) begin
			err_cnt++;
			$display("ch_on fell after %0d cycles with length disabled", n);
		end
		end_test("length expiry");

		wb_write(ADR_NR30, 8'h00);
		wb_write(ADR_NR34, 8'h87); // trigger with the DAC off
		repeat (4) @(negedge cery_2mhz);
		check("ch_on", {7'd0, ch_on}, 8'd0);
		wb_write(ADR_WAVE_BASE, 8'hff);
		wb_write(ADR_WAVE_BASE | 5'd1, 8'hff); // loud first four samples
		wb_write(ADR_NR30, 8'h80);
		wb_write(ADR_NR32, 8'h20);
		wb_write(ADR_NR34, 8'h87);
		@(negedge cery_2mhz);
		check("ch_on", {7'd0, ch_on}, 8'd1);
		repeat (16) @(negedge cery_2mhz);
		check("sample_out", {4'd0, sample_out}, 8'h0f);
		wb_write(ADR_NR30, 8'h00);
		n = 0;
		while (ch_on && n < 4) begin
			@(negedge cery_2mhz);
			n++;
		end
		@(negedge cery_2mhz);
		check("ch_on", {7'd0, ch_on}, 8'd0);
		check("sample_out", {4'd0, sample_out}, 8'd0);
		end_test("DAC off");

		$display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
			test_num, test_fails, err_cnt, i_dut.i_assert.fails);
		if (total_errors() == 0 && test_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- ch3_wave.f
hdl/ch3_pkg.sv
hdl/ch3_regs.sv
hdl/ch3_wave_ram.sv
hdl/ch3_freq_timer.sv
hdl/ch3_length_ctr.sv
hdl/ch3_level_out.sv
hdl/ch3_top.sv
verif/ch3_tb_assert.sv
verif/ch3_tb.sv

//--- run_sim.sh
#!/bin/bash
# compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ch3_tb -f ch3_wave.f -o ch3_sim \
	&& ./obj_dir/ch3_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
